// File: rtl/calc_config.svh
`ifndef CALC_CONFIG_SVH
`define CALC_CONFIG_SVH

// keypad timing, in clk cycles
`define SCAN_DWELL 5          // cycles each column stays low
`define DEBOUNCE_CYCLES 15    // stable cycles needed for press or release

// entry and arithmetic
`define ENTRY_DIGITS 4        // digits past this are dropped
`define CALC_WIDTH 16         // operand and result width, signed

// 4 digits of 9 fit in 14 bits, so the entry never wraps
// a 16x16 product needs the double width inside the ALU

`endif

// File: rtl/keypad_pkg.sv
package keypad_pkg;

    // what a key position means once decoded
    typedef enum logic [2:0] {
        KIND_NONE   = 3'd0,   // unused position, dropped by the scanner
        KIND_DIGIT  = 3'd1,   // 0..9 on the digit field
        KIND_OP     = 3'd2,   // add, subtract or multiply
        KIND_NEGATE = 3'd3,   // sign flip of the entry
        KIND_EQUALS = 3'd4    // run the pending operation
    } key_kind_t;

    // keypad scanner FSM
    typedef enum logic [2:0] {
        SCAN_IDLE    = 3'd0,  // one cycle before scanning resumes
        SCAN_COLS    = 3'd1,  // walking the columns
        SCAN_DEB_PRS = 3'd2,  // press must stay stable
        SCAN_HOLD    = 3'd3,  // event held until ack
        SCAN_WAIT_RL = 3'd4,  // key still down
        SCAN_DEB_RL  = 3'd5   // release must stay stable
    } scan_state_t;

endpackage

// File: rtl/calc_pkg.sv
package calc_pkg;

    // arithmetic operation
    typedef enum logic [1:0] {
        OP_NONE = 2'd0,       // nothing pending
        OP_ADD  = 2'd1,
        OP_SUB  = 2'd2,
        OP_MUL  = 2'd3
    } calc_op_t;

    // calculation controller FSM
    typedef enum logic [1:0] {
        ST_LEFT    = 2'd0,    // typing the left operand
        ST_RIGHT   = 2'd1,    // operator seen, typing the right operand
        ST_COMPUTE = 2'd2,    // ALU busy
        ST_RESULT  = 2'd3     // result shown, becomes the next left operand
    } ctrl_state_t;

endpackage

// File: rtl/key_event_if.sv
interface key_event_if
    import keypad_pkg::*, calc_pkg::*;
();

    logic      valid;         // level, high while an event is held
    key_kind_t kind;          // stable while valid
    logic [3:0] digit;        // value for KIND_DIGIT
    calc_op_t  op;            // operator for KIND_OP
    logic      ack;           // one-cycle pulse from the controller

    modport scanner (
        output valid, kind, digit, op,
        input  ack
    );

    modport controller (
        input  valid, kind, digit, op,
        output ack
    );

endinterface

// File: rtl/keypad_scanner.sv
`include "calc_config.svh"

module keypad_scanner
    import keypad_pkg::*, calc_pkg::*;
(
    input  logic         clk,
    input  logic         nRST,
    input  logic [3:0]   row_in,       // pulled up, low when a key closes
    output logic [3:0]   col_out,      // one column low at a time
    key_event_if.scanner key
);

    localparam int DWELL_W = $clog2(`SCAN_DWELL + 1);
    localparam int DEB_W   = $clog2(`DEBOUNCE_CYCLES + 1);
    localparam int BLANK   = 2;        // rows lag a column change by the sync depth

    scan_state_t        state;
    logic [3:0]         row_meta;
    logic [3:0]         row_sync;
    logic [1:0]         col_idx;       // column currently driven low
    logic [DWELL_W-1:0] dwell_cnt;
    logic [DEB_W-1:0]   deb_cnt;
    logic               key_down;      // any synced row low
    logic               deb_done;
    logic               dwell_done;
    logic               rows_valid;    // synced rows belong to col_idx
    logic [1:0]         row_idx;       // lowest low row
    logic [3:0]         key_pos;       // row * 4 + column
    key_kind_t          dec_kind;
    logic [3:0]         dec_digit;
    calc_op_t           dec_op;
    logic               capture;       // accepted press with a usable key

    // two-flop row synchronizer, idles high
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            row_meta <= 4'b1111;
            row_sync <= 4'b1111;
        end else begin
            row_meta <= row_in;
            row_sync <= row_meta;
        end
    end

    assign key_down   = ~&row_sync;
    assign deb_done   = (deb_cnt == DEB_W'(`DEBOUNCE_CYCLES - 1));
    assign dwell_done = (dwell_cnt == DWELL_W'(`SCAN_DWELL - 1));
    assign rows_valid = (dwell_cnt >= DWELL_W'(BLANK));

    always_comb begin
        col_out          = 4'b1111;
        col_out[col_idx] = 1'b0;
    end

    // lowest row wins if several are low
    always_comb begin
        row_idx = 2'd0;
        for (int r = 3; r >= 0; r--) begin
            if (!row_sync[r]) begin
                row_idx = 2'(r);
            end
        end
    end

    assign key_pos = {row_idx, col_idx};

    // keypad layout: 1 2 3 + / 4 5 6 - / 7 8 9 * / = 0 # neg
    always_comb begin
        dec_kind  = KIND_DIGIT;
        dec_digit = 4'd0;
        dec_op    = OP_NONE;
        case (key_pos)
            4'd0:  dec_digit = 4'd1;
            4'd1:  dec_digit = 4'd2;
            4'd2:  dec_digit = 4'd3;
            4'd4:  dec_digit = 4'd4;
            4'd5:  dec_digit = 4'd5;
            4'd6:  dec_digit = 4'd6;
            4'd8:  dec_digit = 4'd7;
            4'd9:  dec_digit = 4'd8;
            4'd10: dec_digit = 4'd9;
            4'd13: dec_digit = 4'd0;
            4'd3: begin
                dec_kind = KIND_OP;
                dec_op   = OP_ADD;
            end
            4'd7: begin
                dec_kind = KIND_OP;
                dec_op   = OP_SUB;
            end
            4'd11: begin
                dec_kind = KIND_OP;
                dec_op   = OP_MUL;
            end
            4'd12:   dec_kind = KIND_EQUALS;
            4'd15:   dec_kind = KIND_NEGATE;
            default: dec_kind = KIND_NONE;   // position 14 has no function
        endcase
    end

    assign capture = (state == SCAN_DEB_PRS) && key_down && deb_done
                     && (dec_kind != KIND_NONE);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state     <= SCAN_IDLE;
            col_idx   <= 2'd0;
            dwell_cnt <= '0;
            deb_cnt   <= '0;
            key.valid <= 1'b0;
        end else begin
            case (state)
                SCAN_IDLE: begin
                    dwell_cnt <= '0;
                    state     <= SCAN_COLS;
                end
                SCAN_COLS: begin
                    if (key_down && rows_valid) begin
                        deb_cnt <= '0;
                        state   <= SCAN_DEB_PRS;      // column freezes here
                    end else if (dwell_done) begin
                        dwell_cnt <= '0;
                        col_idx   <= col_idx + 2'd1;  // wraps 3 -> 0
                    end else begin
                        dwell_cnt <= dwell_cnt + DWELL_W'(1);
                    end
                end
                SCAN_DEB_PRS: begin
                    if (!key_down) begin
                        dwell_cnt <= '0;              // bounce, rescan same column
                        state     <= SCAN_COLS;
                    end else if (deb_done) begin
                        key.valid <= capture;
                        state     <= capture ? SCAN_HOLD : SCAN_WAIT_RL;
                    end else begin
                        deb_cnt <= deb_cnt + DEB_W'(1);
                    end
                end
                SCAN_HOLD: begin
                    if (key.ack) begin
                        key.valid <= 1'b0;
                        state     <= SCAN_WAIT_RL;
                    end
                end
                SCAN_WAIT_RL: begin
                    if (!key_down) begin
                        deb_cnt <= '0;
                        state   <= SCAN_DEB_RL;
                    end
                end
                SCAN_DEB_RL: begin
                    if (key_down) begin
                        state <= SCAN_WAIT_RL;        // still bouncing
                    end else if (deb_done) begin
                        state <= SCAN_IDLE;
                    end else begin
                        deb_cnt <= deb_cnt + DEB_W'(1);
                    end
                end
                default: state <= SCAN_IDLE;
            endcase
        end
    end

    // event payload, only meaningful while valid is high
    always_ff @(posedge clk) begin
        if (capture) begin
            key.kind  <= dec_kind;
            key.digit <= dec_digit;
            key.op    <= dec_op;
        end
    end

endmodule

// File: rtl/calc_controller.sv
`include "calc_config.svh"

module calc_controller
    import keypad_pkg::*, calc_pkg::*;
(
    input  logic                          clk,
    input  logic                          nRST,
    key_event_if.controller               key,
    output logic                          alu_start,
    output logic signed [`CALC_WIDTH-1:0] alu_a,
    output logic signed [`CALC_WIDTH-1:0] alu_b,
    output calc_op_t                      alu_op,
    input  logic                          alu_done,
    input  logic signed [`CALC_WIDTH-1:0] alu_result,
    input  logic                          alu_overflow,
    output logic signed [`CALC_WIDTH-1:0] display_value,
    output logic                          result_valid,
    output logic                          overflow
);

    localparam int CNT_W = $clog2(`ENTRY_DIGITS + 1);

    ctrl_state_t                   state;
    logic [`CALC_WIDTH-1:0]        entry_mag;   // decimal magnitude being typed
    logic                          entry_neg;   // sign from the negate key
    logic [CNT_W-1:0]              entry_cnt;   // digits taken so far
    logic                          show_entry;  // display follows the entry
    logic signed [`CALC_WIDTH-1:0] entry;
    logic signed [`CALC_WIDTH-1:0] left_opnd;   // also holds the last result
    calc_op_t                      op_reg;
    logic                          ovf_reg;
    logic                          fire;        // event consumed this cycle

    assign entry = entry_neg ? -$signed(entry_mag) : $signed(entry_mag);
    assign fire  = key.ack;                     // payload still stable during ack

    // ack is a single pulse the cycle after valid is first seen
    // no events are taken while the ALU is busy
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            key.ack <= 1'b0;
        end else begin
            key.ack <= key.valid && !key.ack && (state != ST_COMPUTE);
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state      <= ST_LEFT;
            entry_mag  <= '0;
            entry_neg  <= 1'b0;
            entry_cnt  <= '0;
            show_entry <= 1'b1;
            left_opnd  <= '0;
            op_reg     <= OP_NONE;
            ovf_reg    <= 1'b0;
            alu_start  <= 1'b0;
        end else begin
            alu_start <= 1'b0;
            if (state == ST_COMPUTE) begin
                if (alu_done) begin
                    left_opnd  <= alu_result;    // chains into the next operator
                    ovf_reg    <= alu_overflow;
                    op_reg     <= OP_NONE;
                    entry_mag  <= '0;
                    entry_neg  <= 1'b0;
                    entry_cnt  <= '0;
                    show_entry <= 1'b0;
                    state      <= ST_RESULT;
                end
            end else if (fire) begin
                case (key.kind)
                    KIND_DIGIT: begin
                        if (entry_cnt < CNT_W'(`ENTRY_DIGITS)) begin
                            entry_mag <= entry_mag * `CALC_WIDTH'(10)
                                         + `CALC_WIDTH'(key.digit);
                            entry_cnt <= entry_cnt + CNT_W'(1);
                        end
                        show_entry <= 1'b1;
                        if (state == ST_RESULT) begin
                            ovf_reg <= 1'b0;     // fresh calculation
                            state   <= ST_LEFT;
                        end
                    end
                    KIND_NEGATE: begin
                        entry_neg  <= ~entry_neg;
                        show_entry <= 1'b1;
                    end
                    KIND_OP: begin
                        op_reg <= key.op;        // in ST_RIGHT only the op changes
                        if (state == ST_LEFT) begin
                            left_opnd  <= entry;
                            entry_mag  <= '0;
                            entry_neg  <= 1'b0;
                            entry_cnt  <= '0;
                            show_entry <= 1'b0;
                        end
                        state <= ST_RIGHT;
                    end
                    KIND_EQUALS: begin
                        if (state == ST_RIGHT && op_reg != OP_NONE) begin
                            alu_start <= 1'b1;
                            state     <= ST_COMPUTE;
                        end
                    end
                    default: ;                   // none never reaches here
                endcase
            end
        end
    end

    // operands stay put from start until done
    assign alu_a  = left_opnd;
    assign alu_b  = entry;
    assign alu_op = op_reg;

    // result shows straight from the ALU in the done cycle
    assign result_valid  = alu_done;
    assign overflow      = alu_done ? alu_overflow : ovf_reg;
    assign display_value = alu_done   ? alu_result :
                           show_entry ? entry      : left_opnd;

endmodule

// File: rtl/calc_alu.sv
`include "calc_config.svh"

module calc_alu
    import calc_pkg::*;
(
    input  logic                          clk,
    input  logic                          nRST,
    input  logic                          start,
    input  logic signed [`CALC_WIDTH-1:0] a,
    input  logic signed [`CALC_WIDTH-1:0] b,
    input  calc_op_t                      op,
    output logic                          done,
    output logic signed [`CALC_WIDTH-1:0] result,
    output logic                          overflow
);

    localparam int W    = `CALC_WIDTH;
    localparam int WIDE = 2 * `CALC_WIDTH;

    logic signed [WIDE-1:0] wide;       // exact value before truncation
    logic                   wide_ovf;

    always_comb begin
        case (op)
            OP_ADD:  wide = WIDE'(a) + WIDE'(b);   // sign extended operands
            OP_SUB:  wide = WIDE'(a) - WIDE'(b);
            OP_MUL:  wide = WIDE'(a) * WIDE'(b);
            default: wide = '0;
        endcase
    end

    // in range only if the upper half plus the result sign bit all agree
    assign wide_ovf = !(&wide[WIDE-1:W-1] || ~|wide[WIDE-1:W-1]);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            done     <= 1'b0;
            overflow <= 1'b0;
        end else begin
            done <= start;                  // one cycle latency
            if (start) begin
                overflow <= wide_ovf;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            result <= wide[W-1:0];          // wraps like 16-bit hardware
        end
    end

endmodule

// File: rtl/calc_top.sv
`include "calc_config.svh"

module calc_top
    import calc_pkg::*;
(
    input  logic                          clk,
    input  logic                          nRST,
    input  logic [3:0]                    row_in,
    output logic [3:0]                    col_out,
    output logic signed [`CALC_WIDTH-1:0] display_value,
    output logic                          result_valid,
    output logic                          overflow
);

    key_event_if key_if ();             // scanner to controller handshake

    logic                          alu_start;
    logic                          alu_done;
    logic                          alu_overflow;
    logic signed [`CALC_WIDTH-1:0] alu_a;
    logic signed [`CALC_WIDTH-1:0] alu_b;
    logic signed [`CALC_WIDTH-1:0] alu_result;
    calc_op_t                      alu_op;

    keypad_scanner u_scanner (
        .clk     (clk),
        .nRST    (nRST),
        .row_in  (row_in),
        .col_out (col_out),
        .key     (key_if)
    );

    calc_controller u_ctrl (
        .clk           (clk),
        .nRST          (nRST),
        .key           (key_if),
        .alu_start     (alu_start),
        .alu_a         (alu_a),
        .alu_b         (alu_b),
        .alu_op        (alu_op),
        .alu_done      (alu_done),
        .alu_result    (alu_result),
        .alu_overflow  (alu_overflow),
        .display_value (display_value),
        .result_valid  (result_valid),
        .overflow      (overflow)
    );

    calc_alu u_alu (
        .clk      (clk),
        .nRST     (nRST),
        .start    (alu_start),
        .a        (alu_a),
        .b        (alu_b),
        .op       (alu_op),
        .done     (alu_done),
        .result   (alu_result),
        .overflow (alu_overflow)
    );

endmodule

// File: test/keypad_model.sv
module keypad_model (
    input  logic       clk,
    input  logic [3:0] col_out,     // from the DUT, one column low
    input  logic [3:0] key_pos,     // row * 4 + column
    input  logic       pressed,
    input  logic       bounce,      // chatter on the press edge
    output logic [3:0] row_in
);

    localparam int CHATTER = 5;     // contact toggles before it settles

    logic contact;                  // switch closed
    logic pressed_d;
    int   chatter_left;

    initial begin
        contact      = 1'b0;
        pressed_d    = 1'b0;
        chatter_left = 0;
    end

    always @(posedge clk) begin
        pressed_d <= pressed;
        if (pressed && !pressed_d && bounce) begin
            chatter_left <= CHATTER;
            contact      <= 1'b1;
        end else if (chatter_left > 0) begin
            chatter_left <= chatter_left - 1;
            contact      <= (chatter_left == 1) ? pressed : ~contact;   // settles on the last step
        end else begin
            contact <= pressed;
        end
    end

    // rows are pulled up, a closed key shorts its row to its column
    always_comb begin
        row_in = 4'b1111;
        if (contact && !col_out[key_pos[1:0]]) begin
            row_in[key_pos[3:2]] = 1'b0;
        end
    end

endmodule

// File: test/calc_tb.sv
`include "calc_config.svh"

module calc_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int PRESS_LEN    = 3 * `DEBOUNCE_CYCLES;   // down time and the same up time
    localparam int NUM_PRESSES  = 210;                    // upper bound with the long hold as 10
    localparam int NUM_RESETS   = 4;
    localparam longint WATCHDOG = (longint'(NUM_PRESSES) * 2 * PRESS_LEN * 8
                                   + NUM_RESETS * RESET_CYCLES) * CLK_PERIOD;
    localparam int K_DIGIT = 0;
    localparam int K_OP    = 1;                           // val 1 add, 2 subtract, 3 multiply
    localparam int K_NEG   = 2;
    localparam int K_EQ    = 3;

    logic                          clk;
    logic                          nRST;
    logic [3:0]                    row_in;
    logic [3:0]                    col_out;
    logic [3:0]                    key_pos;
    logic                          pressed;
    logic                          bounce;
    logic signed [`CALC_WIDTH-1:0] display_value;
    logic                          result_valid;
    logic                          overflow;
    int errors;
    int checks;
    int seed;
    int rv_seen;                   // result_valid pulses so far
    int rv_value;                  // display_value in the last pulse
    bit rv_ovf;
    int m_mag;                     // reference model of the calculator
    int m_cnt;
    int m_left;
    int m_op;
    int m_state;                   // 0 left entry, 1 right entry, 2 result
    int m_rv_count;
    bit m_neg;
    bit m_show;
    bit m_ovf;

    calc_top u_dut (
        .clk           (clk),
        .nRST          (nRST),
        .row_in        (row_in),
        .col_out       (col_out),
        .display_value (display_value),
        .result_valid  (result_valid),
        .overflow      (overflow)
    );

    keypad_model u_keypad (
        .clk     (clk),
        .col_out (col_out),
        .key_pos (key_pos),
        .pressed (pressed),
        .bounce  (bounce),
        .row_in  (row_in)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG);
        $display("watchdog expired before the key sequences finished");
        $display("Test FAILED");
        $finish;
    end

    always @(posedge clk) begin
        if (result_valid) begin
            rv_seen++;
            rv_value = display_value;
            rv_ovf   = overflow;
        end
    end

    function automatic int wrap16(input longint v);
        logic signed [15:0] t;
        t = v[15:0];
        return int'(t);
    endfunction

    function automatic int model_entry();
        return m_neg ? -m_mag : m_mag;
    endfunction

    function automatic int digit_pos(input int d);
        return (d == 0) ? 13 : (d - 1) + (d - 1) / 3;   // 1..9 fill three columns per row
    endfunction

    function automatic int rand_operand();
        int ndig;
        int mag;
        ndig = 1 + int'($unsigned($random(seed)) % 4);
        mag  = int'($unsigned($random(seed)) % (10 ** ndig));
        return ($random(seed) & 1) ? -mag : mag;
    endfunction

    task automatic check_int(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        nRST <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        check_int("col_out", col_out, 4'b1110);
        check_int("display_value", display_value, 0);
        check_int("result_valid", result_valid, 0);
        check_int("overflow", overflow, 0);
        nRST    <= 1'b1;
        m_mag   = 0;
        m_cnt   = 0;
        m_neg   = 0;
        m_show  = 1;
        m_left  = 0;
        m_op    = 0;
        m_state = 0;
        m_ovf   = 0;
    endtask

    // one press and release with the model updated first and checks after release
    task automatic key_press(input int kind, input int val, input int hold, input bit bnc);
        int     pos;
        longint wide;
        bit     fires;
        fires = 0;
        pos   = 12;
        case (kind)
            K_DIGIT: begin
                pos = digit_pos(val);
                if (m_state == 2) begin
                    m_state = 0;        // fresh calculation
                    m_ovf   = 0;
                end
                if (m_cnt < `ENTRY_DIGITS) begin
                    m_mag = m_mag * 10 + val;
                    m_cnt++;
                end
                m_show = 1;
            end
            K_OP: begin
                pos = 4 * val - 1;      // add 3, subtract 7, multiply 11
                if (m_state == 0) begin
                    m_left = model_entry();
                    m_mag  = 0;
                    m_neg  = 0;
                    m_cnt  = 0;
                    m_show = 0;
                end
                m_op    = val;
                m_state = 1;
            end
            K_NEG: begin
                pos    = 15;
                m_neg  = !m_neg;
                m_show = 1;
            end
            default: begin
                if (m_state == 1 && m_op != 0) begin
                    case (m_op)
                        1:       wide = longint'(m_left) + longint'(model_entry());
                        2:       wide = longint'(m_left) - longint'(model_entry());
                        default: wide = longint'(m_left) * longint'(model_entry());
                    endcase
                    m_ovf   = (wide > 32767) || (wide < -32768);
                    m_left  = wrap16(wide);
                    m_op    = 0;
                    m_mag   = 0;
                    m_neg   = 0;
                    m_cnt   = 0;
                    m_show  = 0;
                    m_state = 2;
                    m_rv_count++;
                    fires   = 1;
                end
            end
        endcase
        @(posedge clk);
        key_pos <= 4'(pos);
        bounce  <= bnc;
        pressed <= 1'b1;
        repeat (hold) @(posedge clk);
        pressed <= 1'b0;
        bounce  <= 1'b0;
        repeat (PRESS_LEN) @(posedge clk);
        check_int("display_value", display_value, m_show ? model_entry() : m_left);
        check_int("overflow", overflow, m_ovf);
        check_int("result_valid pulses", rv_seen, m_rv_count);
        if (fires) begin
            check_int("display_value at result_valid", rv_value, m_left);
            check_int("overflow at result_valid", rv_ovf, m_ovf);
        end
    endtask

    task automatic enter_number(input int value);
        int digs[4];
        int n;
        int mag;
        mag = (value < 0) ? -value : value;
        n   = 0;
        do begin
            digs[n] = mag % 10;
            mag     = mag / 10;
            n++;
        end while (mag > 0);
        for (int i = n - 1; i >= 0; i--) begin
            key_press(K_DIGIT, digs[i], PRESS_LEN, 1'b0);
        end
        if (value < 0) begin
            key_press(K_NEG, 0, PRESS_LEN, 1'b0);
        end
    endtask

    task automatic run_random(input int op, input int count);
        for (int i = 0; i < count; i++) begin
            enter_number(rand_operand());
            key_press(K_OP, op, PRESS_LEN, 1'b0);
            enter_number(rand_operand());
            key_press(K_EQ, 0, PRESS_LEN, 1'b0);
        end
    endtask

    initial begin
        nRST       = 1'b0;
        key_pos    = 4'd0;
        pressed    = 1'b0;
        bounce     = 1'b0;
        seed       = 32'hfaef;
        errors     = 0;
        checks     = 0;
        rv_seen    = 0;
        rv_value   = 0;
        rv_ovf     = 0;
        m_rv_count = 0;
        apply_reset();
        for (int d = 1; d <= 5; d++) begin
            key_press(K_DIGIT, d, PRESS_LEN, 1'b0);    // fifth digit is dropped
        end
        apply_reset();
        run_random(1, 4);
        run_random(2, 4);
        run_random(3, 6);
        apply_reset();
        enter_number(-25);
        key_press(K_OP, 1, PRESS_LEN, 1'b0);
        enter_number(100);
        key_press(K_EQ, 0, PRESS_LEN, 1'b0);
        key_press(K_OP, 3, PRESS_LEN, 1'b0);           // chains from 75
        enter_number(3);
        key_press(K_EQ, 0, PRESS_LEN, 1'b0);
        enter_number(300);
        key_press(K_OP, 3, PRESS_LEN, 1'b0);
        enter_number(-200);
        key_press(K_EQ, 0, PRESS_LEN, 1'b0);           // -60000 wraps and overflows
        apply_reset();
        key_press(K_DIGIT, 7, 10 * PRESS_LEN, 1'b0);   // long hold gives one digit only
        key_press(K_DIGIT, 3, PRESS_LEN, 1'b1);        // contact chatter
        key_press(K_EQ, 0, PRESS_LEN, 1'b0);           // equals without an operator
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: calc_top.f
+incdir+rtl
rtl/keypad_pkg.sv
rtl/calc_pkg.sv
rtl/key_event_if.sv
rtl/keypad_scanner.sv
rtl/calc_controller.sv
rtl/calc_alu.sv
rtl/calc_top.sv
test/keypad_model.sv
test/calc_tb.sv
